/* dcache_top.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_line_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache_top.sv

/* hdl/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
`define DC_XLEN        32
`define DC_LINES       8
`define DC_LINE_WORDS  4   // also the burst length of a line transfer

// addresses with this bit set bypass the cache
`define DC_UNCACHE_BIT 31

// derived field widths
`define DC_BYTE_W      $clog2(`DC_XLEN / 8)
`define DC_OFFSET_W    $clog2(`DC_LINE_WORDS)
`define DC_INDEX_W     $clog2(`DC_LINES)
`define DC_TAG_W       (`DC_XLEN - `DC_INDEX_W - `DC_OFFSET_W - `DC_BYTE_W)

`endif

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  input  logic                 cpu_valid_i,
  input  dcache_pkg::lookup_t  lookup_i,
  input  dcache_pkg::word_t    line_word_i,
  input  logic                 mem_ready_i,
  input  dcache_pkg::word_t    mem_rdata_i,
  output logic                 cpu_done_o,
  output logic                 tag_we_o,
  output logic                 dirty_we_o,
  output logic                 dirty_o,
  output logic                 ld_we_o,
  output dcache_pkg::offset_t  ld_offset_o,
  output dcache_pkg::mask_t    ld_wmask_o,
  output dcache_pkg::word_t    ld_wdata_o,
  output dcache_pkg::word_t    unc_rdata_o,
  output dcache_pkg::mem_req_t mem_req_o,
  output logic                 mem_valid_o
);
  import dcache_pkg::*;

  dc_state_e state_q;
  dc_state_e state_d;
  offset_t   beat_q;
  logic      done_q;
  word_t     unc_rdata_q;

  logic busy;
  logic beat;
  logic last_beat;
  logic accept;

  // done_q blocks the held request from being taken twice
  assign accept    = cpu_valid_i && !done_q && (state_q == IDLE);
  assign busy      = (state_q != IDLE);  // every other state owns the bus
  assign beat      = busy && mem_ready_i;
  assign last_beat = beat && (beat_q == offset_t'(`DC_LINE_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          if (lookup_i.uncached) begin
            state_d = cpu_req_i.write ? UNC_WRITE : UNC_READ;
          end else if (!lookup_i.hit) begin
            state_d = lookup_i.dirty ? WRITE_BACK : REFILL;
          end
        end
      end
      WRITE_BACK, REFILL: begin
        if (last_beat) begin
          state_d = IDLE;  // access looks up again from idle
        end
      end
      UNC_READ, UNC_WRITE: begin
        if (beat) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (accept && lookup_i.hit)
                 || (beat && (state_q == UNC_READ || state_q == UNC_WRITE));
      if (!busy) begin
        beat_q <= '0;
      end else if (beat) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == UNC_READ && beat) begin
      unc_rdata_q <= mem_rdata_i;
    end
  end

  assign cpu_done_o  = done_q;
  assign unc_rdata_o = unc_rdata_q;
  assign mem_valid_o = busy;

  always_comb begin
    tag_we_o    = 1'b0;
    dirty_we_o  = 1'b0;
    dirty_o     = 1'b0;
    ld_we_o     = 1'b0;
    ld_offset_o = lookup_i.offset;
    ld_wmask_o  = '1;
    ld_wdata_o  = mem_rdata_i;
    mem_req_o   = '0;
    case (state_q)
      IDLE: begin
        if (accept && lookup_i.hit && cpu_req_i.write) begin
          ld_we_o    = 1'b1;
          ld_wmask_o = cpu_req_i.wmask;
          ld_wdata_o = cpu_req_i.wdata;
          dirty_we_o = 1'b1;
          dirty_o    = 1'b1;
        end
      end
      WRITE_BACK: begin
        mem_req_o.addr  = {lookup_i.victim_tag, lookup_i.index, beat_q,
                           {`DC_BYTE_W{1'b0}}};
        mem_req_o.write = 1'b1;
        mem_req_o.wdata = line_word_i;
        ld_offset_o     = beat_q;
        dirty_we_o      = last_beat;  // line is clean once written out
      end
      REFILL: begin
        mem_req_o.addr  = {cpu_req_i.addr[`DC_XLEN-1:`DC_OFFSET_W + `DC_BYTE_W], beat_q,
                           {`DC_BYTE_W{1'b0}}};
        ld_offset_o     = beat_q;
        ld_we_o         = beat;
        tag_we_o        = last_beat;  // installs the tag as clean
      end
      UNC_READ: begin
        mem_req_o.addr  = cpu_req_i.addr;
      end
      UNC_WRITE: begin
        mem_req_o.addr  = cpu_req_i.addr;
        mem_req_o.write = 1'b1;
        mem_req_o.wdata = cpu_req_i.wdata;
      end
      default: begin
      end
    endcase
  end

  // a stalled beat is held unchanged until it is taken
  a_beat_hold: assert property (@(posedge clk) disable iff (rst)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o));

endmodule

/* hdl/dcache_line_store.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_line_store (
  input  logic                clk,
  input  dcache_pkg::index_t  index_i,
  input  dcache_pkg::offset_t rd_offset_i,
  input  logic                we_i,
  input  dcache_pkg::offset_t wr_offset_i,
  input  dcache_pkg::mask_t   wmask_i,
  input  dcache_pkg::word_t   wdata_i,
  input  dcache_pkg::word_t   unc_rdata_i,
  input  logic                uncached_i,
  output dcache_pkg::word_t   line_word_o,
  output dcache_pkg::word_t   rdata_o
);
  import dcache_pkg::*;

  word_t data_q [`DC_LINES][`DC_LINE_WORDS];

  // byte-masked write of one word
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < `DC_XLEN / 8; b++) begin
        if (wmask_i[b]) begin
          data_q[index_i][wr_offset_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // combinational read, also feeds the write-back data
  assign line_word_o = data_q[index_i][rd_offset_i];

  // I/O reads come from the captured bus word
  assign rdata_o = uncached_i ? unc_rdata_i : line_word_o;

endmodule

/* hdl/dcache_pkg.sv */
`include "dcache_config.svh"

package dcache_pkg;

  typedef logic [`DC_XLEN-1:0]     addr_t;
  typedef logic [`DC_XLEN-1:0]     word_t;
  typedef logic [`DC_XLEN/8-1:0]   mask_t;  // one bit per byte lane
  typedef logic [`DC_INDEX_W-1:0]  index_t;
  typedef logic [`DC_OFFSET_W-1:0] offset_t;
  typedef logic [`DC_TAG_W-1:0]    tag_t;

  // load/store request from the cpu, held until done
  typedef struct packed {
    addr_t addr;
    logic  write;
    mask_t wmask;
    word_t wdata;
  } cpu_req_t;

  // one beat on the memory bus
  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
  } mem_req_t;

  // result of the tag lookup for the current request
  typedef struct packed {
    logic    hit;
    logic    dirty;      // line valid and modified
    logic    uncached;
    tag_t    victim_tag; // tag currently stored at index
    index_t  index;
    offset_t offset;
  } lookup_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE_BACK,
    REFILL,
    UNC_READ,
    UNC_WRITE
  } dc_state_e;

endpackage

/* hdl/dcache_tag_store.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tag_store (
  input  logic                clk,
  input  logic                rst,
  input  dcache_pkg::addr_t   addr_i,
  input  logic                tag_we_i,
  input  logic                dirty_we_i,
  input  logic                dirty_i,
  output dcache_pkg::lookup_t lookup_o
);
  import dcache_pkg::*;

  tag_t                 tag_q [`DC_LINES];
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  tag_t    addr_tag;
  index_t  addr_index;
  offset_t addr_offset;
  logic    addr_uncached;

  // tag | index | word offset | byte offset
  assign addr_tag      = addr_i[`DC_XLEN-1 -: `DC_TAG_W];
  assign addr_index    = addr_i[`DC_BYTE_W + `DC_OFFSET_W +: `DC_INDEX_W];
  assign addr_offset   = addr_i[`DC_BYTE_W +: `DC_OFFSET_W];
  assign addr_uncached = addr_i[`DC_UNCACHE_BIT];

  always_comb begin
    lookup_o.hit        = valid_q[addr_index] && (tag_q[addr_index] == addr_tag)
                          && !addr_uncached;
    lookup_o.dirty      = valid_q[addr_index] && dirty_q[addr_index];
    lookup_o.uncached   = addr_uncached;
    lookup_o.victim_tag = tag_q[addr_index];
    lookup_o.index      = addr_index;
    lookup_o.offset     = addr_offset;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (tag_we_i) begin
        valid_q[addr_index] <= 1'b1;
      end
      if (tag_we_i || dirty_we_i) begin
        dirty_q[addr_index] <= dirty_i;  // clean on refill, set on write hit
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_q[addr_index] <= addr_tag;
    end
  end

  // the I/O region must never be allocated
  a_no_uncached_alloc: assert property (@(posedge clk) disable iff (rst)
    tag_we_i |-> !addr_uncached);

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  input  logic                 cpu_valid_i,
  input  logic                 mem_ready_i,
  input  dcache_pkg::word_t    mem_rdata_i,
  output dcache_pkg::word_t    cpu_rdata_o,
  output logic                 cpu_done_o,
  output dcache_pkg::mem_req_t mem_req_o,
  output logic                 mem_valid_o
);
  import dcache_pkg::*;

  lookup_t lookup;
  logic    tag_we;
  logic    dirty_we;
  logic    dirty;
  logic    ld_we;
  offset_t ld_offset;
  mask_t   ld_wmask;
  word_t   ld_wdata;
  word_t   line_word;
  word_t   unc_rdata;

  dcache_tag_store u_tag_store (
    .clk        (clk),
    .rst        (rst),
    .addr_i     (cpu_req_i.addr),
    .tag_we_i   (tag_we),
    .dirty_we_i (dirty_we),
    .dirty_i    (dirty),
    .lookup_o   (lookup)
  );

  dcache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .cpu_req_i   (cpu_req_i),
    .cpu_valid_i (cpu_valid_i),
    .lookup_i    (lookup),
    .line_word_i (line_word),
    .mem_ready_i (mem_ready_i),
    .mem_rdata_i (mem_rdata_i),
    .cpu_done_o  (cpu_done_o),
    .tag_we_o    (tag_we),
    .dirty_we_o  (dirty_we),
    .dirty_o     (dirty),
    .ld_we_o     (ld_we),
    .ld_offset_o (ld_offset),
    .ld_wmask_o  (ld_wmask),
    .ld_wdata_o  (ld_wdata),
    .unc_rdata_o (unc_rdata),
    .mem_req_o   (mem_req_o),
    .mem_valid_o (mem_valid_o)
  );

  // one offset serves both ports, the FSM never reads and writes different words
  dcache_line_store u_line_store (
    .clk         (clk),
    .index_i     (lookup.index),
    .rd_offset_i (ld_offset),
    .we_i        (ld_we),
    .wr_offset_i (ld_offset),
    .wmask_i     (ld_wmask),
    .wdata_i     (ld_wdata),
    .unc_rdata_i (unc_rdata),
    .uncached_i  (lookup.uncached),
    .line_word_o (line_word),
    .rdata_o     (cpu_rdata_o)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_dcache_top -f dcache_top.f
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

./obj_dir/Vtb_dcache_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^test passed$" sim.log
exit $?

/* tests/mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
  parameter int SEED = 20301
) (
  input  logic                 clk,
  input  logic                 stall_en_i,
  input  dcache_pkg::mem_req_t req_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output dcache_pkg::word_t    rdata_o
);
  import dcache_pkg::*;

  int          seed = SEED;
  logic [31:0] rnd;
  word_t       salt;
  word_t       mem [addr_t];  // written words only

  initial begin
    salt    = $random(seed);
    ready_o = 1'b1;
    rdata_o = '0;
  end

  // ready and read data change with the stimulus, on the falling edge
  always @(negedge clk) begin
    rnd = $random(seed);
    ready_o <= stall_en_i ? rnd[0] : 1'b1;
    if (mem.exists(req_i.addr)) begin
      rdata_o <= mem[req_i.addr];
    end else begin
      rdata_o <= {req_i.addr[15:0], req_i.addr[31:16]} ^ salt;  // unwritten fill
    end
  end

  always @(posedge clk) begin
    if (valid_i && ready_o && req_i.write) begin
      mem[req_i.addr] = req_i.wdata;
    end
  end

endmodule

/* tests/tb_dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache_top;
  import dcache_pkg::*;

  localparam int    MAX_CYCLES = 2000;  // two passes need ~150 cycles even with stalls
  localparam addr_t ADDR_A     = 32'h0000_1038;
  localparam addr_t ADDR_B     = 32'h0000_2038;  // same index as A, other tag
  localparam addr_t ADDR_U     = 32'h8000_0034;  // I/O region, not line aligned
  localparam addr_t LINE_MASK  = ~addr_t'(`DC_LINE_WORDS * 4 - 1);

  logic     clk;
  logic     rst;
  cpu_req_t cpu_req;
  logic     cpu_valid;
  logic     mem_ready;
  word_t    mem_rdata;
  word_t    cpu_rdata;
  logic     cpu_done;
  mem_req_t mem_req;
  logic     mem_valid;
  logic     stall_en;

  word_t    ref_mem [addr_t];  // coherent view of memory
  mem_req_t beats [$];
  int       valid_cycles;
  int       errors = 0;
  int       tests = 0;
  int       cycles = 0;

  dcache_top dcache_top_i (
    .clk         (clk),
    .rst         (rst),
    .cpu_req_i   (cpu_req),
    .cpu_valid_i (cpu_valid),
    .mem_ready_i (mem_ready),
    .mem_rdata_i (mem_rdata),
    .cpu_rdata_o (cpu_rdata),
    .cpu_done_o  (cpu_done),
    .mem_req_o   (mem_req),
    .mem_valid_o (mem_valid)
  );

  mem_model #(.SEED(20301)) u_mem (
    .clk        (clk),
    .stall_en_i (stall_en),
    .req_i      (mem_req),
    .valid_i    (mem_valid),
    .ready_o    (mem_ready),
    .rdata_o    (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("run stopped, no result after %0d cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // bus monitor that learns unseen words and checks the rest against the reference
  always @(posedge clk) begin
    if (!rst && mem_valid) begin
      valid_cycles++;
    end
    if (!rst && mem_valid && mem_ready) begin
      beats.push_back(mem_req);
      if (mem_req.write && !mem_req.addr[`DC_UNCACHE_BIT]) begin
        check_word("write-back data", mem_req.wdata, ref_mem[mem_req.addr]);
      end else if (!mem_req.write && ref_mem.exists(mem_req.addr)) begin
        check_word("memory read word", mem_rdata, ref_mem[mem_req.addr]);
      end else if (!mem_req.write) begin
        ref_mem[mem_req.addr] = mem_rdata;
      end
    end
  end

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else begin
      $display("ERROR %0t: memory request changed during a stall", $time);
      errors++;
    end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    a_word: assert (got == exp) else begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(input int idx, input addr_t addr, input logic write);
    a_beat_seen: assert (idx < beats.size()) else begin
      $display("memory beat %0d never appeared", idx);
      errors++;
    end
    if (idx < beats.size()) begin
      check_word("beat address", beats[idx].addr, addr);
      check_word("beat write flag", word_t'(beats[idx].write), word_t'(write));
    end
  endtask

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, mask_t mask);
    word_t bits;
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      bits[8*b +: 8] = {8{mask[b]}};
    end
    return (old_w & ~bits) | (new_w & bits);
  endfunction

  // holds the request until done, then leaves one idle cycle
  task automatic access(input addr_t addr, input logic write, input mask_t wmask,
                        input word_t wdata, output word_t rdata, output int lat);
    cpu_req.addr  = addr;
    cpu_req.write = write;
    cpu_req.wmask = wmask;
    cpu_req.wdata = wdata;
    cpu_valid     = 1'b1;
    lat           = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!cpu_done);
    rdata     = cpu_rdata;
    cpu_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("%s%s: %s", stall_en ? "stalled " : "", name,
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  task automatic run_pass(input int round);
    word_t rdata;
    word_t wdata;
    int    lat;
    int    err0;
    err0 = errors;
    rst  = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_word("done and valid after reset", word_t'({cpu_done, mem_valid}), 0);
    beats.delete();
    access(ADDR_A, 1'b0, '0, '0, rdata, lat);
    check_word("refill beats", beats.size(), `DC_LINE_WORDS);
    for (int k = 0; k < `DC_LINE_WORDS; k++) begin
      check_beat(k, (ADDR_A & LINE_MASK) + 4 * k, 1'b0);
    end
    check_word("read after refill", rdata, ref_mem[ADDR_A]);
    finish_test("test 1 read miss refill", err0);

    err0  = errors;
    wdata = 32'hA1B2_C3D4 + round;
    valid_cycles = 0;
    access(ADDR_A, 1'b1, 4'b0101, wdata, rdata, lat);
    check_word("write hit latency", lat, 1);
    ref_mem[ADDR_A] = merge_bytes(ref_mem[ADDR_A], wdata, 4'b0101);
    access(ADDR_A, 1'b0, '0, '0, rdata, lat);
    check_word("read hit latency", lat, 1);
    check_word("read after masked write", rdata, ref_mem[ADDR_A]);
    check_word("bus cycles during hits", valid_cycles, 0);
    finish_test("test 2 masked write hit", err0);

    err0 = errors;
    beats.delete();
    access(ADDR_B, 1'b0, '0, '0, rdata, lat);
    check_word("write-back and refill beats", beats.size(), 2 * `DC_LINE_WORDS);
    for (int k = 0; k < `DC_LINE_WORDS; k++) begin
      check_beat(k, (ADDR_A & LINE_MASK) + 4 * k, 1'b1);
      check_beat(`DC_LINE_WORDS + k, (ADDR_B & LINE_MASK) + 4 * k, 1'b0);
    end
    check_word("read after write-back", rdata, ref_mem[ADDR_B]);
    finish_test("test 3 dirty victim", err0);

    err0  = errors;
    wdata = 32'h5EED_0000 + round;
    beats.delete();
    access(ADDR_U, 1'b1, 4'hF, wdata, rdata, lat);
    check_word("uncached write beats", beats.size(), 1);
    check_beat(0, ADDR_U, 1'b1);
    check_word("uncached write data", beats.size() > 0 ? beats[0].wdata : '0, wdata);
    ref_mem[ADDR_U] = wdata;
    for (int r = 0; r < 2; r++) begin
      beats.delete();
      access(ADDR_U, 1'b0, '0, '0, rdata, lat);
      check_word("uncached read beats", beats.size(), 1);
      check_beat(0, ADDR_U, 1'b0);
      check_word("uncached read data", rdata, ref_mem[ADDR_U]);
    end
    finish_test("test 4 uncached access", err0);
  endtask

  initial begin
    rst          = 1'b1;
    cpu_valid    = 1'b0;
    cpu_req      = '0;
    stall_en     = 1'b0;
    valid_cycles = 0;
    run_pass(0);
    stall_en = 1'b1;  // test 5 repeats everything with ready stalls
    run_pass(1);
    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
